//--- page_unit_macros.svh
/*
 * Page unit parameters
 * Widths, page count and command queue depth
 */
`ifndef PAGE_UNIT_MACROS_SVH
`define PAGE_UNIT_MACROS_SVH

// --------------------
// Address and data widths
`define PT_PAGE_W     10            // Page index width
`define PT_PAGES      1024          // Number of pages
`define PT_VADDR_W    20            // Virtual address, page in top bits
`define PT_FRAME_W    20            // Frame number and command data

// --------------------
// Command flow
`define PT_FIFO_DEPTH 4             // Queue entries, also initial host credits
`define PT_CREDIT_W   2             // Credits returned per cycle, 0 to 2

`endif

//--- page_unit_pkg.sv
/*
 * Page unit types
 * Command opcodes, engine states and the command, memory op and response words
 */
`include "page_unit_macros.svh"

package page_unit_pkg;

    // --------------------
    // Opcodes
    typedef enum logic [3:0] {
        PT_NOP          = 4'd0,     // Absorbed by issue
        PT_SET_INDEX    = 4'd1,     // Load physical page index
        PT_WRITE_MAP    = 4'd2,     // Page map write, page from vaddr
        PT_READ_MAP     = 4'd3,     // Page map read, page from vaddr
        PT_WRITE_ACCESS = 4'd4,     // Invalid and read-only bits
        PT_READ_ACCESS  = 4'd5,     // Access word readback
        PT_WRITE_REPRIO = 4'd6,     // Reprioritize bit write
        PT_READ_REPRIO  = 4'd7,     // Reprioritize bit read
        PT_START_FILL   = 4'd8      // Set reprio bits from index to last page
    } pt_op_e;

    // Engine FSM
    typedef enum logic {
        ENG_IDLE = 1'b0,            // Popping commands
        ENG_FILL = 1'b1             // Fill sequence running
    } pt_eng_state_e;

    // --------------------
    // Host command, 44 bits
    typedef struct packed {
        pt_op_e                  op;
        logic [`PT_VADDR_W-1:0]  addr;  // Virtual address
        logic [`PT_FRAME_W-1:0]  data;
    } pt_host_cmd_t;

    // Queued memory operation, 34 bits
    typedef struct packed {
        pt_op_e                  op;
        logic [`PT_PAGE_W-1:0]   page;  // Resolved page
        logic [`PT_FRAME_W-1:0]  data;
    } pt_mem_op_t;

    // Read response, 35 bits
    typedef struct packed {
        pt_op_e                  op;
        logic [`PT_PAGE_W-1:0]   page;
        logic [`PT_FRAME_W-1:0]  data;
        logic                    fault; // Page invalid on map read
    } pt_rsp_t;

endpackage

//--- page_cmd_issue.sv
/*
 * Command issue stage
 * Decodes host commands, keeps the physical page index register and
 * forwards memory operations to the queue one cycle after acceptance
 */
`include "page_unit_macros.svh"

module page_cmd_issue (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_cmd_valid,    // Host command strobe
    input  page_unit_pkg::pt_host_cmd_t i_cmd,
    output logic                        o_push,         // Op to queue
    output page_unit_pkg::pt_mem_op_t   o_op,
    output logic                        o_absorb        // Command used up here
);
    import page_unit_pkg::*;

    logic [`PT_PAGE_W-1:0] page_index;      // Physical page index register
    logic [`PT_PAGE_W-1:0] cmd_vpage;       // Page bits of vaddr
    logic [`PT_PAGE_W-1:0] op_page;         // Page sent with the op
    logic                  forward;         // Op goes on to the engine

    assign cmd_vpage = i_cmd.addr[`PT_VADDR_W-1 -: `PT_PAGE_W];

    // --------------------
    // Opcode decode
    always_comb begin
        forward = 1'b0;
        op_page = page_index;               // Default source is the index
        case (i_cmd.op)
            PT_WRITE_MAP,
            PT_READ_MAP: begin
                forward = 1'b1;
                op_page = cmd_vpage;        // Map ops address by vaddr
            end
            PT_WRITE_ACCESS,
            PT_READ_ACCESS,
            PT_WRITE_REPRIO,
            PT_READ_REPRIO,
            PT_START_FILL: begin
                forward = 1'b1;             // Fill starts at current index
            end
            default: begin
                forward = 1'b0;             // NOP, SET_INDEX, unknown
            end
        endcase
    end

    // --------------------
    // Control and index register
    always_ff @(posedge clk) begin
        if (reset) begin
            page_index <= '0;
            o_push     <= 1'b0;
            o_absorb   <= 1'b0;
        end else begin
            o_push   <= i_cmd_valid & forward;
            o_absorb <= i_cmd_valid & ~forward;   // Returns a credit at once
            if (i_cmd_valid && i_cmd.op == PT_SET_INDEX) begin
                page_index <= cmd_vpage;    // Visible to the next command
            end
        end
    end

    // Operation payload
    always_ff @(posedge clk) begin
        if (i_cmd_valid) begin
            o_op.op   <= i_cmd.op;
            o_op.page <= op_page;
            o_op.data <= i_cmd.data;
        end
    end

endmodule

//--- page_cmd_queue.sv
/*
 * Command queue
 * Circular FIFO of memory operations, returns a credit per pop and per absorb
 */
`include "page_unit_macros.svh"

module page_cmd_queue #(
    parameter int DEPTH = `PT_FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_push,         // Write an op
    input  page_unit_pkg::pt_mem_op_t   i_op,
    input  logic                        i_absorb,       // Issue consumed a command
    input  logic                        i_pop,          // Engine takes the head
    output logic                        o_not_empty,
    output page_unit_pkg::pt_mem_op_t   o_head,
    output logic [`PT_CREDIT_W-1:0]     o_credit_return
);
    import page_unit_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CR_W  = `PT_CREDIT_W;

    pt_mem_op_t       fifo_mem [DEPTH];     // Entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                // Occupancy
    logic             do_push;
    logic             do_pop;

    assign o_not_empty = (count != '0);
    assign o_head      = fifo_mem[rd_ptr];
    assign do_push     = i_push & (count != CNT_W'(DEPTH));
    assign do_pop      = i_pop & o_not_empty;

    // --------------------
    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= i_op;
        end
    end

    // Pointers and count
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // --------------------
    // Credit return, one cycle after the event
    always_ff @(posedge clk) begin
        if (reset) begin
            o_credit_return <= '0;
        end else begin
            o_credit_return <= CR_W'(do_pop) + CR_W'(i_absorb);
        end
    end

endmodule

//--- page_mem_engine.sv
/*
 * Page memory engine
 * Holds page map, access and reprioritize memories, runs the fill sequence
 * and answers read commands one cycle after the pop
 */
`include "page_unit_macros.svh"

module page_mem_engine (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_not_empty,    // Queue has an op
    input  page_unit_pkg::pt_mem_op_t   i_head,
    output logic                        o_pop,
    output logic                        o_rsp_valid,    // One-cycle response strobe
    output page_unit_pkg::pt_rsp_t      o_rsp,
    output logic                        o_fill_busy     // High while filling
);
    import page_unit_pkg::*;

    localparam int PAGE_W  = `PT_PAGE_W;
    localparam int FRAME_W = `PT_FRAME_W;

    // --------------------
    // Page memories
    logic [FRAME_W-1:0] pg_map    [`PT_PAGES];  // Virtual page to frame
    logic               pg_inv    [`PT_PAGES];  // Access blocked
    logic               pg_ro     [`PT_PAGES];  // Write blocked
    logic               pg_reprio [`PT_PAGES];  // Reprioritize request

    pt_eng_state_e      state;
    logic [PAGE_W-1:0]  fill_page;              // Next page to set
    logic               fill_last;              // Last page reached
    logic               is_read;                // Head op answers
    logic [FRAME_W-1:0] rd_data;
    logic               rd_fault;

    assign o_pop       = (state == ENG_IDLE) & i_not_empty;  // No pop while filling
    assign o_fill_busy = (state == ENG_FILL);
    assign fill_last   = (fill_page == PAGE_W'(`PT_PAGES - 1));

    // --------------------
    // Engine FSM and fill counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ENG_IDLE;
            fill_page <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (o_pop && i_head.op == PT_START_FILL) begin
                        state     <= ENG_FILL;
                        fill_page <= i_head.page;   // Start at issuing index
                    end
                end
                ENG_FILL: begin
                    if (fill_last) begin
                        state <= ENG_IDLE;
                    end else begin
                        fill_page <= fill_page + 1'b1;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // --------------------
    // Memory writes
    always_ff @(posedge clk) begin
        if (o_pop && i_head.op == PT_WRITE_MAP) begin
            pg_map[i_head.page] <= i_head.data;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop && i_head.op == PT_WRITE_ACCESS) begin
            pg_inv[i_head.page] <= i_head.data[1];
            pg_ro[i_head.page]  <= i_head.data[2];
        end
    end

    always_ff @(posedge clk) begin
        if (state == ENG_FILL) begin
            pg_reprio[fill_page] <= 1'b1;   // One page per clock
        end else if (o_pop && i_head.op == PT_WRITE_REPRIO) begin
            pg_reprio[i_head.page] <= i_head.data[0];
        end
    end

    // --------------------
    // Read mux
    always_comb begin
        is_read  = 1'b0;
        rd_data  = '0;
        rd_fault = 1'b0;
        case (i_head.op)
            PT_READ_MAP: begin
                is_read  = 1'b1;
                rd_data  = pg_map[i_head.page];
                rd_fault = pg_inv[i_head.page];     // Invalid page faults
            end
            PT_READ_ACCESS: begin
                is_read    = 1'b1;
                rd_data[2] = pg_ro[i_head.page];
                rd_data[1] = pg_inv[i_head.page];   // Bit 0 stays zero
            end
            PT_READ_REPRIO: begin
                is_read    = 1'b1;
                rd_data[0] = pg_reprio[i_head.page];
            end
            default: begin
                is_read = 1'b0;                     // Writes and fill are silent
            end
        endcase
    end

    // Response register
    always_ff @(posedge clk) begin
        if (reset) begin
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= o_pop & is_read;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_rsp.op    <= i_head.op;
            o_rsp.page  <= i_head.page;
            o_rsp.data  <= rd_data;
            o_rsp.fault <= rd_fault;
        end
    end

endmodule

//--- page_unit_top.sv
/*
 * Page unit
 * Command issue, command queue and page memory engine in a row
 */
`include "page_unit_macros.svh"

module page_unit_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_cmd_valid,    // Host spends a credit
    input  page_unit_pkg::pt_host_cmd_t i_cmd,
    output logic [`PT_CREDIT_W-1:0]     o_credit_return,
    output logic                        o_rsp_valid,
    output page_unit_pkg::pt_rsp_t      o_rsp,
    output logic                        o_fill_busy
);
    import page_unit_pkg::*;

    // --------------------
    // Stage links
    logic       issue_push;                 // Issue to queue
    pt_mem_op_t issue_op;
    logic       issue_absorb;
    logic       queue_not_empty;            // Queue to engine
    pt_mem_op_t queue_head;
    logic       engine_pop;

    page_cmd_issue u_issue (
        .clk         (clk),
        .reset       (reset),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .o_push      (issue_push),
        .o_op        (issue_op),
        .o_absorb    (issue_absorb)
    );

    page_cmd_queue #(
        .DEPTH (`PT_FIFO_DEPTH)
    ) u_queue (
        .clk             (clk),
        .reset           (reset),
        .i_push          (issue_push),
        .i_op            (issue_op),
        .i_absorb        (issue_absorb),
        .i_pop           (engine_pop),
        .o_not_empty     (queue_not_empty),
        .o_head          (queue_head),
        .o_credit_return (o_credit_return)
    );

    page_mem_engine u_engine (
        .clk         (clk),
        .reset       (reset),
        .i_not_empty (queue_not_empty),
        .i_head      (queue_head),
        .o_pop       (engine_pop),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp       (o_rsp),
        .o_fill_busy (o_fill_busy)
    );

endmodule

//--- tb_page_unit.sv
/*
 * Page unit testbench
 * Credit-driven host, reference model of the page memories and in-order
 * response checks for map, access, reprioritize and fill traffic
 */
`include "page_unit_macros.svh"

module tb_page_unit;
    import page_unit_pkg::*;

    localparam int PAGE_W   = `PT_PAGE_W;
    localparam int OFF_W    = `PT_VADDR_W - `PT_PAGE_W;
    localparam int DEPTH    = `PT_FIFO_DEPTH;
    localparam int WAIT_TMO = 3000;                 // Cycles, longer than any fill

    logic                    clk;
    logic                    reset;
    logic                    i_cmd_valid;
    pt_host_cmd_t            i_cmd;
    logic [`PT_CREDIT_W-1:0] o_credit_return;
    logic                    o_rsp_valid;
    pt_rsp_t                 o_rsp;
    logic                    o_fill_busy;

    // --------------------
    // Host and reference model state
    int                  credits;                   // Host credit counter
    int                  check_errors;
    int                  timeout_errors;
    int                  proto_errors;
    int                  fills_done;
    int                  busy_len;                  // Cycles of current fill
    int                  p;
    logic                busy_prev;
    logic                bp_check;                  // Credit freeze check armed
    logic                saw_zero;                  // Credits hit 0 while filling
    logic [31:0]         lfsr_state;
    logic [PAGE_W-1:0]   ref_index;                 // Model of the index register
    logic [PAGE_W-1:0]   fill_start;
    logic [`PT_FRAME_W-1:0] ref_map [`PT_PAGES];
    logic                ref_inv    [`PT_PAGES];
    logic                ref_ro     [`PT_PAGES];
    logic                ref_reprio [`PT_PAGES];
    pt_rsp_t             exp_q [$];                 // Outstanding reads, in order
    pt_rsp_t             exp_rsp;

    page_unit_top DUT (
        .clk             (clk),
        .reset           (reset),
        .i_cmd_valid     (i_cmd_valid),
        .i_cmd           (i_cmd),
        .o_credit_return (o_credit_return),
        .o_rsp_valid     (o_rsp_valid),
        .o_rsp           (o_rsp),
        .o_fill_busy     (o_fill_busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // Period 40
    end

    // --------------------
    // Helpers
    function void report_fail(input string sig, input logic [63:0] exp,
                              input logic [63:0] act);
        check_errors++;
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, sig, exp, act);
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [`PT_VADDR_W-1:0] vaddr(input logic [PAGE_W-1:0] pg,
                                                      input logic [OFF_W-1:0] off);
        return {pg, off};                           // Page in the top bits
    endfunction

    // One cycle on the falling edge, collect returned credits
    task automatic tick();
        @(negedge clk);
        i_cmd_valid = 1'b0;
        credits     = credits + o_credit_return;
        assert (credits >= 0 && credits <= DEPTH)
            else report_fail("host credits", DEPTH, credits);
        if (credits == 0 && o_fill_busy) begin
            saw_zero = 1'b1;
        end
    endtask

    task automatic send_cmd(input pt_op_e op, input logic [`PT_VADDR_W-1:0] addr,
                            input logic [`PT_FRAME_W-1:0] data);
        int                waited;
        logic [PAGE_W-1:0] page;
        pt_rsp_t           exp;
        waited = 0;
        page   = (op == PT_WRITE_MAP || op == PT_READ_MAP) ? addr[`PT_VADDR_W-1 -: PAGE_W]
                                                            : ref_index;
        tick();
        while (credits == 0 && waited < WAIT_TMO) begin  // Wait for a credit
            tick();
            waited++;
        end
        if (credits == 0) begin
            timeout_errors++;
            $display("Timeout at %0t: host got no credit back for %0d cycles", $time, waited);
        end else begin
            i_cmd_valid = 1'b1;
            i_cmd.op    = op;
            i_cmd.addr  = addr;
            i_cmd.data  = data;
            credits--;
            exp      = '0;
            exp.op   = op;
            exp.page = page;
            case (op)
                PT_SET_INDEX:    ref_index = addr[`PT_VADDR_W-1 -: PAGE_W];
                PT_WRITE_MAP:    ref_map[page] = data;
                PT_WRITE_ACCESS: begin
                    ref_inv[page] = data[1];
                    ref_ro[page]  = data[2];
                end
                PT_WRITE_REPRIO: ref_reprio[page] = data[0];
                PT_START_FILL:   fill_start = page;
                PT_READ_MAP: begin
                    exp.data  = ref_map[page];
                    exp.fault = ref_inv[page];      // Invalid page faults
                    exp_q.push_back(exp);
                end
                PT_READ_ACCESS: begin
                    exp.data[2] = ref_ro[page];
                    exp.data[1] = ref_inv[page];
                    exp_q.push_back(exp);
                end
                PT_READ_REPRIO: begin
                    exp.data[0] = ref_reprio[page];
                    exp_q.push_back(exp);
                end
                default: ;                          // NOP and unknown ops
            endcase
        end
    endtask

    task automatic drain_traffic();
        int waited;
        waited = 0;
        tick();
        while (!(exp_q.size() == 0 && credits == DEPTH && !o_fill_busy)
               && waited < WAIT_TMO) begin
            tick();
            waited++;
        end
        if (waited >= WAIT_TMO) begin
            timeout_errors++;
            $display("Timeout at %0t: traffic did not drain, %0d reads still open",
                     $time, exp_q.size());
        end
        assert (credits == DEPTH) else report_fail("host credits", DEPTH, credits);
    endtask

    task automatic wait_fill_done(input int target);
        int waited;
        waited = 0;
        while (fills_done < target && waited < WAIT_TMO) begin
            tick();
            waited++;
        end
        if (fills_done < target) begin
            timeout_errors++;
            $display("Timeout at %0t: fill sequence never finished", $time);
        end
    endtask

    // --------------------
    // Response and fill monitors
    always @(negedge clk) begin
        if (!reset && o_rsp_valid) begin
            if (exp_q.size() == 0) begin
                proto_errors++;
                $display("Response at %0t with no read outstanding", $time);
            end else begin
                exp_rsp = exp_q.pop_front();
                assert (o_rsp.op === exp_rsp.op) else report_fail("o_rsp.op", exp_rsp.op, o_rsp.op);
                assert (o_rsp.page === exp_rsp.page)
                    else report_fail("o_rsp.page", exp_rsp.page, o_rsp.page);
                assert (o_rsp.data === exp_rsp.data)
                    else report_fail("o_rsp.data", exp_rsp.data, o_rsp.data);
                assert (o_rsp.fault === exp_rsp.fault)
                    else report_fail("o_rsp.fault", exp_rsp.fault, o_rsp.fault);
            end
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            busy_prev = 1'b0;
            busy_len  = 0;
        end else begin
            if (o_fill_busy) begin
                busy_len++;
            end else if (busy_prev) begin           // Fill just ended
                assert (busy_len == `PT_PAGES - fill_start)
                    else report_fail("o_fill_busy cycles", `PT_PAGES - fill_start, busy_len);
                for (p = fill_start; p < `PT_PAGES; p++) begin
                    ref_reprio[p] = 1'b1;
                end
                busy_len = 0;
                fills_done++;
            end
            busy_prev = o_fill_busy;
        end
    end

    // Outputs quiet during and right after reset
    assert property (@(posedge clk) reset |=> (o_rsp_valid == 1'b0))
        else report_fail("o_rsp_valid", 0, $sampled(o_rsp_valid));
    assert property (@(posedge clk) reset |=> (o_credit_return == '0))
        else report_fail("o_credit_return", 0, $sampled(o_credit_return));
    assert property (@(posedge clk) reset |=> (o_fill_busy == 1'b0))
        else report_fail("o_fill_busy", 0, $sampled(o_fill_busy));

    // No credits come back once a fill is running
    assert property (@(posedge clk) disable iff (reset)
                     (bp_check && o_fill_busy && $past(o_fill_busy)) |-> (o_credit_return == '0))
        else report_fail("o_credit_return", 0, $sampled(o_credit_return));

    // --------------------
    // Stimulus
    initial begin
        logic [PAGE_W-1:0]      pg;
        logic [PAGE_W-1:0]      base_pg;
        logic [PAGE_W-1:0]      pages_used [8];
        logic [OFF_W-1:0]       off;
        logic [`PT_FRAME_W-1:0] frame;
        logic [1:0]             acc;
        int                     k;
        lfsr_state     = 32'hf025;
        credits        = DEPTH;
        check_errors   = 0;
        timeout_errors = 0;
        proto_errors   = 0;
        fills_done     = 0;
        bp_check       = 1'b0;
        saw_zero       = 1'b0;
        ref_index      = '0;
        fill_start     = '0;
        reset          = 1'b1;
        i_cmd_valid    = 1'b0;
        i_cmd          = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Map and access bits on random pages
        for (k = 0; k < 8; k++) begin
            pg            = lfsr_bits(PAGE_W);
            pages_used[k] = pg;
            acc           = lfsr_bits(2);
            off           = lfsr_bits(OFF_W);
            frame         = lfsr_bits(`PT_FRAME_W);
            send_cmd(PT_SET_INDEX, vaddr(pg, '0), '0);
            send_cmd(PT_WRITE_ACCESS, '0, {acc, 1'b0});     // ro, inv, zero
            send_cmd(PT_WRITE_MAP, vaddr(pg, off), frame);
            send_cmd(PT_NOP, '0, '0);
            send_cmd(PT_READ_ACCESS, '0, '0);
            off = lfsr_bits(OFF_W);
            send_cmd(PT_READ_MAP, vaddr(pg, off), '0);
        end
        send_cmd(pt_op_e'(4'hf), '0, '0);           // Unknown op is absorbed
        for (k = 0; k < 8; k++) begin               // Overwrite, last frame wins
            frame = lfsr_bits(`PT_FRAME_W);
            send_cmd(PT_WRITE_MAP, vaddr(pages_used[k], '0), frame);
            send_cmd(PT_READ_MAP, vaddr(pages_used[k], '1), '0);
        end
        drain_traffic();

        // Fill from a mid-range page
        base_pg = 10'd384 + PAGE_W'(lfsr_bits(8));
        for (k = 0; k < 8; k++) begin
            send_cmd(PT_SET_INDEX, vaddr(base_pg - 10'd4 + PAGE_W'(k), '0), '0);
            send_cmd(PT_WRITE_REPRIO, '0, '0);
        end
        send_cmd(PT_SET_INDEX, vaddr('1, '0), '0);  // Last page
        send_cmd(PT_WRITE_REPRIO, '0, '0);
        send_cmd(PT_SET_INDEX, vaddr(base_pg, '0), '0);
        send_cmd(PT_START_FILL, '0, '0);
        wait_fill_done(1);
        for (k = 0; k < 8; k++) begin
            send_cmd(PT_SET_INDEX, vaddr(base_pg - 10'd4 + PAGE_W'(k), '0), '0);
            send_cmd(PT_READ_REPRIO, '0, '0);
        end
        send_cmd(PT_SET_INDEX, vaddr('1, '0), '0);
        send_cmd(PT_READ_REPRIO, '0, '0);
        drain_traffic();

        // Back-pressure behind a fill
        base_pg = 10'd700 + PAGE_W'(lfsr_bits(6));
        acc     = lfsr_bits(2);
        send_cmd(PT_SET_INDEX, vaddr(base_pg, '0), '0);
        send_cmd(PT_WRITE_ACCESS, '0, {acc, 1'b0});
        drain_traffic();
        bp_check = 1'b1;
        saw_zero = 1'b0;
        send_cmd(PT_START_FILL, '0, '0);
        for (k = 0; k < 6; k++) begin
            if (k % 2 == 0) begin
                send_cmd(PT_READ_MAP, vaddr(pages_used[k], '0), '0);
            end else begin
                send_cmd(PT_READ_ACCESS, '0, '0);
            end
        end
        if (!saw_zero) begin
            proto_errors++;
            $display("Host credits never reached zero while the fill was running");
        end
        wait_fill_done(2);
        bp_check = 1'b0;
        drain_traffic();

        $display("Error counts: %0d check, %0d timeout, %0d protocol",
                 check_errors, timeout_errors, proto_errors);
        if (check_errors + timeout_errors + proto_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
page_unit_pkg.sv
page_cmd_issue.sv
page_cmd_queue.sv
page_mem_engine.sv
page_unit_top.sv
tb_page_unit.sv
